// File: Makefile
# Verilator build and run for the SMC testbench
# override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= smc_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --assert -j 0
EXE       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST) -o V$(TOP)

run: compile
	./$(EXE) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/fifo.sv
// scan-code FIFO, power-of-two depth
// extra pointer bit tells full from empty
`timescale 1ns/1ns

module fifo #(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic       clk6x,
    input  logic       resetn,    // sync, active low
    input  logic [7:0] wport_i,
    input  logic       wenq_i,    // never while full
    output logic [7:0] rport_o,   // head, valid when not empty
    input  logic       rdeq_i,
    output logic       full_o,
    output logic       empty_o
);
    localparam int AW = FIFO_DEPTH_LOG2;

    logic [7:0] mem [2**AW];
    logic [AW:0] wptr;
    logic [AW:0] rptr;

    always_ff @(posedge clk6x)
    begin
        if (wenq_i)
            mem[wptr[AW-1:0]] <= wport_i;
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            wptr <= '0;
            rptr <= '0;
        end else
        begin
            wptr <= wptr + (AW+1)'(wenq_i);
            rptr <= rptr + (AW+1)'(rdeq_i);
        end
    end

    assign rport_o = mem[rptr[AW-1:0]];
    assign empty_o = (wptr == rptr);
    assign full_o  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

    // the register block must gate both sides
    a_no_overflow:  assert property (@(posedge clk6x) disable iff (!resetn)
        full_o |-> !wenq_i);
    a_no_underflow: assert property (@(posedge clk6x) disable iff (!resetn)
        empty_o |-> !rdeq_i);

endmodule

// File: src/i2c_slave.sv
// I2C slave FSM with START and STOP detection
// acks its own address and every written byte, serves read bytes MSB first
`timescale 1ns/1ns

module i2c_slave import smc_pkg::*; #(
    parameter logic [6:0] SLAVE_ADDRESS = 7'h42
) (
    input  logic       clk6x,
    input  logic       resetn,        // sync, active low
    input  logic       I2C_SDA_i,     // SDA line state
    input  logic       I2C_SCL_i,     // SCL line state
    output logic       I2C_SDADR0_o,  // 1 pulls SDA low
    output i2c_dev_t   i2c_dev_o,
    input  logic [7:0] txbyte_i       // next byte for the master
);
    typedef enum logic [2:0] {
        S_IDLE, S_ADDR, S_ADDR_ACK, S_WDATA, S_WACK, S_RDATA, S_RACK
    } state_t;

    state_t     state;
    logic [1:0] sda_sync;
    logic [1:0] scl_sync;
    logic       sda_q;
    logic       scl_q;
    logic       scl_rise;      // registered bus events
    logic       scl_fall;
    logic       start_det;
    logic       stop_det;
    logic [3:0] bitcnt;
    logic [7:0] shreg;         // incoming bits
    logic [7:0] txreg;         // outgoing bits
    logic       sda_dr;
    logic       devsel;
    logic       rw;
    logic       byte_done;
    logic       rxbyte_v;
    logic       mst_ack;       // ack bit seen from master
    logic       load_tx;

    // byte handed to the master at the fall closing an ack slot
    assign load_tx = scl_fall &&
                     ((state == S_ADDR_ACK && rw) || (state == S_RACK && mst_ack));

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            sda_sync  <= 2'b11;    // bus idles high
            scl_sync  <= 2'b11;
            sda_q     <= 1'b1;
            scl_q     <= 1'b1;
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end else
        begin
            sda_sync  <= {sda_sync[0], I2C_SDA_i};
            scl_sync  <= {scl_sync[0], I2C_SCL_i};
            sda_q     <= sda_sync[1];
            scl_q     <= scl_sync[1];
            scl_rise  <= scl_sync[1] & ~scl_q;
            scl_fall  <= ~scl_sync[1] & scl_q;
            // SDA moving while SCL high
            start_det <= scl_sync[1] & scl_q & sda_q & ~sda_sync[1];
            stop_det  <= scl_sync[1] & scl_q & ~sda_q & sda_sync[1];
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            state     <= S_IDLE;
            bitcnt    <= 4'd0;
            sda_dr    <= 1'b0;
            devsel    <= 1'b0;
            rw        <= 1'b0;
            byte_done <= 1'b0;
            rxbyte_v  <= 1'b0;
            mst_ack   <= 1'b0;
        end else
        begin
            rxbyte_v  <= byte_done;   // one more stage, shreg is stable by then
            byte_done <= 1'b0;
            if (stop_det)
            begin
                state  <= S_IDLE;
                sda_dr <= 1'b0;
                devsel <= 1'b0;
            end else if (start_det)
            begin
                state  <= S_ADDR;     // also a repeated start
                bitcnt <= 4'd0;
                sda_dr <= 1'b0;
            end else
            begin
                case (state)
                    S_ADDR, S_WDATA:
                    begin
                        if (scl_rise)
                        begin
                            shreg     <= {shreg[6:0], sda_sync[1]};
                            bitcnt    <= bitcnt + 4'd1;
                            byte_done <= (state == S_WDATA) && (bitcnt == 4'd7);
                        end else if (scl_fall && bitcnt == 4'd8)
                        begin
                            bitcnt <= 4'd0;
                            if (state == S_WDATA)
                            begin
                                sda_dr <= 1'b1;   // ack data byte
                                state  <= S_WACK;
                            end else if (shreg[7:1] == SLAVE_ADDRESS)
                            begin
                                sda_dr <= 1'b1;   // ack own address
                                devsel <= 1'b1;
                                rw     <= shreg[0];
                                state  <= S_ADDR_ACK;
                            end else
                            begin
                                devsel <= 1'b0;   // someone else's transfer
                                state  <= S_IDLE;
                            end
                        end
                    end
                    S_ADDR_ACK, S_WACK, S_RACK:
                    begin
                        if (scl_rise)
                        begin
                            mst_ack <= ~sda_sync[1];
                        end
                        if (load_tx)
                        begin
                            txreg  <= txbyte_i;
                            sda_dr <= ~txbyte_i[7];   // MSB goes out right away
                            bitcnt <= 4'd0;
                            state  <= S_RDATA;
                        end else if (scl_fall)
                        begin
                            sda_dr <= 1'b0;
                            bitcnt <= 4'd0;
                            // NACK from master ends the read
                            state  <= (state == S_RACK) ? S_IDLE : S_WDATA;
                        end
                    end
                    S_RDATA:
                    begin
                        if (scl_fall)
                        begin
                            bitcnt <= bitcnt + 4'd1;
                            txreg  <= {txreg[6:0], 1'b0};
                            if (bitcnt == 4'd7)
                            begin
                                sda_dr <= 1'b0;   // free SDA for master's ack
                                state  <= S_RACK;
                            end else
                            begin
                                sda_dr <= ~txreg[6];
                            end
                        end
                    end
                    default:
                    begin
                        sda_dr <= 1'b0;
                    end
                endcase
            end
        end
    end

    assign I2C_SDADR0_o = sda_dr;
    assign i2c_dev_o = '{devsel: devsel, rw: rw, rxbyte: shreg,
                         rxbyte_v: rxbyte_v, txbyte_deq: load_tx};

    // bus is released whenever the slave is not in a transfer
    a_idle_released: assert property (@(posedge clk6x) disable iff (!resetn)
        (state == S_IDLE) |-> !I2C_SDADR0_o);

endmodule

// File: src/ps2_port.sv
// PS/2 host port receiving device frames and sending command bytes
// inhibit and request-to-send timed in microsecond ticks
`timescale 1ns/1ns

module ps2_port import smc_pkg::*; (
    input  logic         clk6x,
    input  logic         resetn,         // sync, active low
    input  logic         ck1us_i,        // 1T every microsecond
    input  logic         PS2_CLK_i,      // CLK line state
    input  logic         PS2_DATA_i,     // DATA line state
    output logic         PS2_CLKDR0_o,   // 1 pulls CLK low
    output logic         PS2_DATADR0_o,  // 1 pulls DATA low
    output ps2_rx_t      ps2_rx_o,
    input  logic [7:0]   cmd_tx_i,
    input  logic         cmd_tx_v_i,     // taken only while busy is low
    output ps2_tx_stat_t ps2_tx_stat_o
);
    localparam logic [13:0] INHIBIT_US = 14'd100;
    localparam logic [13:0] TIMEOUT_US = 14'd15000;   // device went silent

    typedef enum logic [1:0] {P_IDLE, P_RX, P_INHIBIT, P_TX} pstate_t;

    pstate_t     state;
    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_q;
    logic        clk_fall;
    logic [3:0]  bitcnt;
    logic [9:0]  rxsh;        // data, parity, stop
    logic [9:0]  frame;
    logic [8:0]  txsh;        // parity above data
    logic [13:0] tmr;         // ticks since last clock fall
    logic        clkdr;
    logic        datadr;
    logic [7:0]  code;
    logic        code_v;
    logic        acked;
    logic        errd;

    assign clk_fall = clk_q & ~clk_sync[1];
    assign frame    = {dat_sync[1], rxsh[9:1]};   // LSB arrives first

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            state    <= P_IDLE;
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_q    <= 1'b1;
            bitcnt   <= 4'd0;
            tmr      <= 14'd0;
            clkdr    <= 1'b0;      // both lines released
            datadr   <= 1'b0;
            code_v   <= 1'b0;
            acked    <= 1'b0;
            errd     <= 1'b0;
        end else
        begin
            clk_sync <= {clk_sync[0], PS2_CLK_i};
            dat_sync <= {dat_sync[0], PS2_DATA_i};
            clk_q    <= clk_sync[1];
            code_v   <= 1'b0;
            acked    <= 1'b0;
            errd     <= 1'b0;
            if (clk_fall)
                tmr <= 14'd0;
            else if (ck1us_i)
                tmr <= tmr + 14'd1;

            case (state)
                P_IDLE:
                begin
                    if (cmd_tx_v_i)
                    begin
                        txsh  <= {~^cmd_tx_i, cmd_tx_i};   // odd parity
                        clkdr <= 1'b1;                     // inhibit
                        tmr   <= 14'd0;
                        state <= P_INHIBIT;
                    end else if (clk_fall && !dat_sync[1])
                    begin
                        bitcnt <= 4'd1;    // start bit seen
                        state  <= P_RX;
                    end
                end
                P_RX:
                begin
                    if (clk_fall)
                    begin
                        rxsh   <= frame;
                        bitcnt <= bitcnt + 4'd1;
                        if (bitcnt == 4'd10)
                        begin
                            state <= P_IDLE;
                            // keep only frames with odd parity and a stop bit
                            if (^frame[8:0] && frame[9])
                            begin
                                code   <= frame[7:0];
                                code_v <= 1'b1;
                            end
                        end
                    end else if (tmr == TIMEOUT_US)
                    begin
                        state <= P_IDLE;   // lost clock mid-frame
                    end
                end
                P_INHIBIT:
                begin
                    if (tmr == INHIBIT_US)
                    begin
                        datadr <= 1'b1;    // start bit as request to send
                        clkdr  <= 1'b0;    // device clocks from here
                        bitcnt <= 4'd0;
                        tmr    <= 14'd0;
                        state  <= P_TX;
                    end
                end
                P_TX:
                begin
                    if (clk_fall)
                    begin
                        bitcnt <= bitcnt + 4'd1;
                        if (bitcnt < 4'd9)
                        begin
                            datadr <= ~txsh[0];   // data bits then parity
                            txsh   <= {1'b0, txsh[8:1]};
                        end else if (bitcnt == 4'd9)
                        begin
                            datadr <= 1'b0;       // stop bit
                        end else
                        begin
                            acked <= ~dat_sync[1];   // device pulls ack low
                            errd  <= dat_sync[1];
                            state <= P_IDLE;
                        end
                    end else if (tmr == TIMEOUT_US)
                    begin
                        datadr <= 1'b0;
                        errd   <= 1'b1;
                        state  <= P_IDLE;
                    end
                end
                default:
                begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

    assign PS2_CLKDR0_o  = clkdr;
    assign PS2_DATADR0_o = datadr;
    assign ps2_rx_o      = '{code: code, valid: code_v};
    assign ps2_tx_stat_o = '{busy: (state != P_IDLE), acked: acked, errd: errd};

    // a transfer ends acked or in error but never both
    a_tx_outcome: assert property (@(posedge clk6x) disable iff (!resetn)
        !(ps2_tx_stat_o.acked && ps2_tx_stat_o.errd));

endmodule

// File: src/pulser.sv
// microsecond tick generator, one clk6x pulse per period
`timescale 1ns/1ns

module pulser #(
    parameter int CLK_PER_US = 48
) (
    input  logic clk6x,
    input  logic resetn,   // sync, active low
    output logic ck1us_o   // 1T tick
);
    localparam int CW = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
    localparam logic [CW-1:0] RELOAD = CW'(CLK_PER_US - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            cnt     <= RELOAD;   // first tick CLK_PER_US cycles out
            ck1us_o <= 1'b0;
        end else
        begin
            ck1us_o <= (cnt == '0);
            cnt     <= (cnt == '0) ? RELOAD : cnt - 1'b1;
        end
    end

endmodule

// File: src/smc.sv
// system management controller top, I2C slave at 0x42
// register block, keyboard command queue and status register
`timescale 1ns/1ns

module smc import smc_pkg::*; #(
    parameter int         CLK_PER_US      = 48,
    parameter logic [6:0] SLAVE_ADDRESS   = 7'h42,
    parameter int         FIFO_DEPTH_LOG2 = 3
) (
    input  logic clk6x,
    input  logic resetn,          // sync, active low
    input  logic I2C_SDA_i,
    input  logic I2C_SCL_i,
    output logic I2C_SDADR0_o,    // 1 pulls SDA low
    input  logic PS2K_CLK_i,
    input  logic PS2K_DATA_i,
    output logic PS2K_CLKDR_o,    // 1 pulls CLK low
    output logic PS2K_DATADR_o    // 1 pulls DATA low
);
    i2c_dev_t     dev;
    logic [7:0]   txbyte;          // presented to the master
    logic         ck1us;
    ps2_rx_t      kbd_rx;
    ps2_tx_stat_t kbd_tx;
    logic [7:0]   cmd;             // byte offered to the port
    logic         cmd_v;
    logic [7:0]   cmd2;            // queued second byte
    logic         cmd2_v;
    logic [7:0]   regnum;
    logic [7:0]   kbd_stat;
    logic [1:0]   byteidx;         // written bytes in this transfer
    logic         fifo_full;
    logic         fifo_empty;
    logic         fifo_enq;
    logic         fifo_deq;
    logic [7:0]   fifo_head;

    i2c_slave #(.SLAVE_ADDRESS(SLAVE_ADDRESS)) i2cslv (
        .clk6x        (clk6x),
        .resetn       (resetn),
        .I2C_SDA_i    (I2C_SDA_i),
        .I2C_SCL_i    (I2C_SCL_i),
        .I2C_SDADR0_o (I2C_SDADR0_o),
        .i2c_dev_o    (dev),
        .txbyte_i     (txbyte)
    );

    pulser #(.CLK_PER_US(CLK_PER_US)) pulser_1us (
        .clk6x   (clk6x),
        .resetn  (resetn),
        .ck1us_o (ck1us)
    );

    ps2_port ps2kbd (
        .clk6x         (clk6x),
        .resetn        (resetn),
        .ck1us_i       (ck1us),
        .PS2_CLK_i     (PS2K_CLK_i),
        .PS2_DATA_i    (PS2K_DATA_i),
        .PS2_CLKDR0_o  (PS2K_CLKDR_o),
        .PS2_DATADR0_o (PS2K_DATADR_o),
        .ps2_rx_o      (kbd_rx),
        .cmd_tx_i      (cmd),
        .cmd_tx_v_i    (cmd_v),
        .ps2_tx_stat_o (kbd_tx)
    );

    // codes arriving on a full buffer are lost
    assign fifo_enq = kbd_rx.valid & ~fifo_full;
    // pop only when a real code went out, 0x00 means empty
    assign fifo_deq = dev.devsel & dev.rw & dev.txbyte_deq &
                      (regnum == SMCREG_READ_KBD_BUF) & (txbyte != 8'h00);

    fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) kbdfifo (
        .clk6x   (clk6x),
        .resetn  (resetn),
        .wport_i (kbd_rx.code),
        .wenq_i  (fifo_enq),
        .rport_o (fifo_head),
        .rdeq_i  (fifo_deq),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    // read data follows the selected register every cycle
    always_ff @(posedge clk6x)
    begin
        case (regnum)
            SMCREG_READ_KBD_BUF:      txbyte <= fifo_empty ? 8'h00 : fifo_head;
            SMCREG_READ_PS2_KBD_STAT: txbyte <= kbd_stat;
            default:                  txbyte <= 8'hFF;
        endcase
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            regnum   <= 8'h00;
            byteidx  <= 2'd0;
            cmd_v    <= 1'b0;
            cmd2_v   <= 1'b0;
            kbd_stat <= PS2_CMD_STAT_IDLE;
        end else
        begin
            // port takes cmd in any cycle it is not busy
            if (cmd_v && !kbd_tx.busy)
            begin
                cmd_v  <= cmd2_v;
                cmd2_v <= 1'b0;
                if (cmd2_v)
                    cmd <= cmd2;
            end

            if (kbd_tx.acked)
                kbd_stat <= PS2_CMD_STAT_ACK;
            else if (kbd_tx.errd)
                kbd_stat <= PS2_CMD_STAT_ERR;

            if (!dev.devsel)
            begin
                byteidx <= 2'd0;
            end else if (dev.rxbyte_v)
            begin
                if (byteidx != 2'd3)
                    byteidx <= byteidx + 2'd1;   // saturate, extra bytes ignored
                case (byteidx)
                    2'd0: regnum <= dev.rxbyte;
                    2'd1:
                    begin
                        if (regnum == SMCREG_SEND_PS2_KBD_CMD ||
                            regnum == SMCREG_SEND_PS2_KBD_2BCMD)
                        begin
                            cmd      <= dev.rxbyte;
                            cmd_v    <= 1'b1;
                            cmd2_v   <= 1'b0;
                            kbd_stat <= PS2_CMD_STAT_PENDING;
                        end
                    end
                    2'd2:
                    begin
                        if (regnum == SMCREG_SEND_PS2_KBD_2BCMD)
                        begin
                            if (cmd_v && kbd_tx.busy)
                            begin
                                cmd2   <= dev.rxbyte;   // first byte still waiting
                                cmd2_v <= 1'b1;
                            end else
                            begin
                                cmd   <= dev.rxbyte;    // first byte already taken
                                cmd_v <= 1'b1;
                            end
                        end
                    end
                    default:
                    begin
                        regnum <= regnum;
                    end
                endcase
            end
        end
    end

endmodule

// File: src/smc_pkg.sv
// register numbers of the SMC map
// keyboard command status codes
// packed structs passed between the SMC blocks

package smc_pkg;

    // register numbers, first written byte of a transfer
    localparam logic [7:0] SMCREG_READ_KBD_BUF        = 8'h07;  // pop one scan code
    localparam logic [7:0] SMCREG_READ_PS2_KBD_STAT   = 8'h18;  // command status
    localparam logic [7:0] SMCREG_SEND_PS2_KBD_CMD    = 8'h19;  // 1-byte command
    localparam logic [7:0] SMCREG_SEND_PS2_KBD_2BCMD  = 8'h1A;  // 2-byte command

    // status byte values
    localparam logic [7:0] PS2_CMD_STAT_IDLE    = 8'h00;
    localparam logic [7:0] PS2_CMD_STAT_PENDING = 8'h01;  // sent, waiting for ack bit
    localparam logic [7:0] PS2_CMD_STAT_ACK     = 8'hFA;
    localparam logic [7:0] PS2_CMD_STAT_ERR     = 8'hFE;

    // device side of the I2C slave
    typedef struct packed {
        logic       devsel;      // addressed, until STOP
        logic       rw;          // 1 = master reads
        logic [7:0] rxbyte;      // last byte written by master
        logic       rxbyte_v;    // 1T strobe
        logic       txbyte_deq;  // 1T, txbyte was taken
    } i2c_dev_t;

    // scan code from the keyboard
    typedef struct packed {
        logic [7:0] code;
        logic       valid;       // 1T strobe
    } ps2_rx_t;

    // host-to-device transfer status
    typedef struct packed {
        logic busy;              // rx or tx frame in progress
        logic acked;             // 1T, device pulled the ack bit low
        logic errd;              // 1T, no ack or device timed out
    } ps2_tx_stat_t;

endpackage

// File: tb.f
src/smc_pkg.sv
src/i2c_slave.sv
src/pulser.sv
src/ps2_port.sv
src/fifo.sv
src/smc.sv
test/smc_tb.sv

// File: test/smc_tb.sv
// testbench for the SMC top level
// I2C master model, PS/2 keyboard model, reference model and checks
`timescale 1ns/1ns

module smc_tb import smc_pkg::*;;
    localparam int CLK_PER_US = 12;
    localparam int SCL_PHASE  = 10;      // cycles per SCL half period
    localparam int KBD_PHASE  = 40;      // cycles per PS/2 clock half period
    localparam int KBD_DEPTH  = 8;
    localparam logic [7:0] I2C_WADDR = {7'h42, 1'b0};
    localparam logic [7:0] I2C_RADDR = {7'h42, 1'b1};
    // run length from the test list below
    localparam int N_TXN   = 24;         // I2C reads and writes
    localparam int N_KBD   = 15;         // keyboard to host frames
    localparam int N_HOST  = 4;          // host to keyboard frames
    localparam int I2C_TXN_CYC  = 4 * 9 * 2 * SCL_PHASE + 8 * SCL_PHASE;
    localparam int KBD_FRM_CYC  = 11 * 2 * KBD_PHASE + KBD_PHASE;
    localparam int HOST_FRM_CYC = 100 * CLK_PER_US + 13 * 2 * KBD_PHASE;
    localparam int TIMEOUT_CYC  = 2 * (N_TXN * I2C_TXN_CYC + N_KBD * KBD_FRM_CYC +
                                       N_HOST * HOST_FRM_CYC) + 100;

    logic       clk6x;
    logic       resetn;
    logic       m_sda_low;               // master pulls SDA
    logic       m_scl_low;
    logic       k_clk_low;               // keyboard pulls CLK
    logic       k_data_low;
    logic       sda_dr;
    logic       kbd_clkdr;
    logic       kbd_datadr;
    logic       sda_line;
    logic       scl_line;
    logic       ps2_clk;
    logic       ps2_data;
    logic       ps2_quiet;               // no command sent yet
    logic       ps2_flagged;
    logic [7:0] lfsr = 8'd46;
    logic [7:0] ref_q[$];                // expected buffer contents
    logic [7:0] ref_stat = PS2_CMD_STAT_IDLE;
    logic [7:0] cmd_q[$];                // bytes the keyboard should see
    int         errors = 0;
    int         checks = 0;
    int         cycles;

    // open-drain wiring is low if either side pulls
    assign sda_line = !(m_sda_low || sda_dr);
    assign scl_line = !m_scl_low;
    assign ps2_clk  = !(k_clk_low || kbd_clkdr);
    assign ps2_data = !(k_data_low || kbd_datadr);

    smc #(.CLK_PER_US(CLK_PER_US), .SLAVE_ADDRESS(7'h42), .FIFO_DEPTH_LOG2(3)) dut_i (
        .clk6x         (clk6x),
        .resetn        (resetn),
        .I2C_SDA_i     (sda_line),
        .I2C_SCL_i     (scl_line),
        .I2C_SDADR0_o  (sda_dr),
        .PS2K_CLK_i    (ps2_clk),
        .PS2K_DATA_i   (ps2_data),
        .PS2K_CLKDR_o  (kbd_clkdr),
        .PS2K_DATADR_o (kbd_datadr)
    );

    initial
    begin
        clk6x = 1'b0;
        forever #2 clk6x = ~clk6x;
    end

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk6x);
        #1;                                // inputs move 1 ns after the edge
    endtask

    // 8-bit Fibonacci LFSR with taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic next_code(output logic [7:0] code);
        code = 8'h00;
        while (code == 8'h00)              // zero reads as empty so it is never sent
        begin
            for (int i = 0; i < 8; i++)
            begin
                lfsr = lfsr_next(lfsr);
                code = {code[6:0], lfsr[0]};
            end
        end
    endtask

    // expected read data from the model state
    function automatic logic [7:0] predict_read(input logic [7:0] regnum);
        if (regnum == SMCREG_READ_KBD_BUF)
            return (ref_q.size() > 0) ? ref_q[0] : 8'h00;
        if (regnum == SMCREG_READ_PS2_KBD_STAT)
            return ref_stat;
        return 8'hFF;
    endfunction

    task automatic i2c_bit(input logic b, output logic s);
        wait_cycles(SCL_PHASE / 2);
        m_sda_low = !b;                    // SDA moves mid low phase
        wait_cycles(SCL_PHASE / 2);
        m_scl_low = 1'b0;
        wait_cycles(SCL_PHASE / 2);
        s = sda_line;                      // sample mid high phase
        wait_cycles(SCL_PHASE / 2);
        m_scl_low = 1'b1;
    endtask

    task automatic i2c_start();
        wait_cycles(SCL_PHASE / 2);
        m_sda_low = 1'b0;                  // SDA released first for a repeated start
        wait_cycles(SCL_PHASE / 2);
        m_scl_low = 1'b0;
        wait_cycles(SCL_PHASE);
        m_sda_low = 1'b1;                  // SDA falls while SCL high
        wait_cycles(SCL_PHASE);
        m_scl_low = 1'b1;
    endtask

    task automatic i2c_stop();
        wait_cycles(SCL_PHASE / 2);
        m_sda_low = 1'b1;
        wait_cycles(SCL_PHASE / 2);
        m_scl_low = 1'b0;
        wait_cycles(SCL_PHASE);
        m_sda_low = 1'b0;                  // SDA rises while SCL high
        wait_cycles(SCL_PHASE);
    endtask

    task automatic i2c_send(input logic [7:0] b);
        logic s;
        for (int i = 7; i >= 0; i--)
            i2c_bit(b[i], s);
        i2c_bit(1'b1, s);                  // slave acks by pulling low
        check("I2C ack", 8'(s), 8'h00);
    endtask

    task automatic i2c_recv(input logic nack, output logic [7:0] b);
        logic s;
        b = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            i2c_bit(1'b1, s);
            b = {b[6:0], s};               // MSB first
        end
        i2c_bit(nack, s);
    endtask

    task automatic reg_write(input logic [7:0] regnum, input int nbytes,
                             input logic [7:0] b0, input logic [7:0] b1);
        i2c_start();
        i2c_send(I2C_WADDR);
        i2c_send(regnum);
        i2c_send(b0);
        if (nbytes > 1)
            i2c_send(b1);
        i2c_stop();
    endtask

    task automatic reg_read(input logic [7:0] regnum, output logic [7:0] data);
        i2c_start();
        i2c_send(I2C_WADDR);
        i2c_send(regnum);
        i2c_start();                       // repeated start into the read
        i2c_send(I2C_RADDR);
        i2c_recv(1'b1, data);              // single byte then NACK
        i2c_stop();
    endtask

    task automatic read_compare(input logic [7:0] regnum, input string name);
        logic [7:0] got;
        logic [7:0] exp;
        exp = predict_read(regnum);
        reg_read(regnum, got);
        check(name, got, exp);
        if (regnum == SMCREG_READ_KBD_BUF && ref_q.size() > 0)
            void'(ref_q.pop_front());
    endtask

    task automatic send_command(input logic [7:0] regnum, input int nbytes,
                                input logic [7:0] b0, input logic [7:0] b1);
        reg_write(regnum, nbytes, b0, b1);
        cmd_q.push_back(b0);
        if (nbytes > 1)
            cmd_q.push_back(b1);
        ref_stat = PS2_CMD_STAT_PENDING;
    endtask

    // keyboard to host frame with data changing mid high phase
    task automatic kbd_send(input logic [7:0] code);
        logic [10:0] fr;
        fr = {1'b1, ~^code, code, 1'b0};   // stop, odd parity, data, start
        for (int i = 0; i < 11; i++)
        begin
            k_data_low = !fr[i];
            wait_cycles(KBD_PHASE / 2);
            k_clk_low = 1'b1;
            wait_cycles(KBD_PHASE);
            k_clk_low = 1'b0;
            wait_cycles(KBD_PHASE / 2);
        end
        k_data_low = 1'b0;
        wait_cycles(KBD_PHASE);
        if (ref_q.size() < KBD_DEPTH)      // full buffer drops the code
            ref_q.push_back(code);
    endtask

    // host to keyboard frame sampled on the rising clock
    task automatic kbd_receive(input logic give_ack);
        logic [9:0] bits;
        logic [7:0] exp;
        while (!(kbd_datadr && !kbd_clkdr))   // request to send
        begin
            wait_cycles(1);
        end
        wait_cycles(KBD_PHASE);
        for (int i = 0; i < 10; i++)
        begin
            k_clk_low = 1'b1;
            wait_cycles(KBD_PHASE);
            k_clk_low = 1'b0;
            bits[i] = ps2_data;
            wait_cycles(KBD_PHASE);
        end
        k_data_low = give_ack;             // ack bit pulled low or left high
        wait_cycles(KBD_PHASE / 4);
        k_clk_low = 1'b1;
        wait_cycles(KBD_PHASE);
        k_clk_low = 1'b0;
        wait_cycles(KBD_PHASE / 4);
        k_data_low = 1'b0;
        wait_cycles(KBD_PHASE);
        exp = cmd_q.pop_front();
        check("kbd command byte", bits[7:0], exp);
        check("kbd command parity", 8'(bits[8]), 8'(~^exp));
        check("kbd command stop bit", 8'(bits[9]), 8'h01);
        ref_stat = give_ack ? PS2_CMD_STAT_ACK : PS2_CMD_STAT_ERR;
    endtask

    // PS/2 lines must stay released until a command is written
    always @(negedge clk6x)
    begin
        if (ps2_quiet && !ps2_flagged && (kbd_clkdr || kbd_datadr))
        begin
            check("PS2K drive outputs", {6'd0, kbd_clkdr, kbd_datadr}, 8'h00);
            ps2_flagged = 1'b1;
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYC)
        begin
            @(posedge clk6x);
            cycles++;
        end
        $display("timeout after %0d cycles, a bus handshake never completed", cycles);
        $display("checks: %0d errors: %0d", checks, errors + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        logic [7:0] c;
        resetn      = 1'b0;
        m_sda_low   = 1'b0;
        m_scl_low   = 1'b0;
        k_clk_low   = 1'b0;
        k_data_low  = 1'b0;
        ps2_quiet   = 1'b0;
        ps2_flagged = 1'b0;
        repeat (2) @(posedge clk6x);
        #1 resetn = 1'b1;
        wait_cycles(5);

        // all lines released after reset
        check("I2C_SDADR0_o", 8'(sda_dr), 8'h00);
        check("PS2K_CLKDR_o", 8'(kbd_clkdr), 8'h00);
        check("PS2K_DATADR_o", 8'(kbd_datadr), 8'h00);
        ps2_quiet = 1'b1;
        read_compare(SMCREG_READ_PS2_KBD_STAT, "status after reset");
        read_compare(SMCREG_READ_KBD_BUF, "kbd buffer after reset");

        // five codes read back in order then empty
        repeat (5)
        begin
            next_code(c);
            kbd_send(c);
        end
        repeat (6) read_compare(SMCREG_READ_KBD_BUF, "kbd buffer");

        // ten codes into eight entries
        repeat (10)
        begin
            next_code(c);
            kbd_send(c);
        end
        repeat (9) read_compare(SMCREG_READ_KBD_BUF, "kbd buffer overflow");
        ps2_quiet = 1'b0;

        // one-byte command goes pending then acked
        send_command(SMCREG_SEND_PS2_KBD_CMD, 1, 8'hF4, 8'h00);
        read_compare(SMCREG_READ_PS2_KBD_STAT, "status pending");
        kbd_receive(1'b1);
        read_compare(SMCREG_READ_PS2_KBD_STAT, "status acked");

        // two-byte command sends both frames in order
        send_command(SMCREG_SEND_PS2_KBD_2BCMD, 2, 8'hED, 8'h02);
        kbd_receive(1'b1);
        kbd_receive(1'b1);
        read_compare(SMCREG_READ_PS2_KBD_STAT, "status after 2-byte cmd");

        // ack bit withheld
        send_command(SMCREG_SEND_PS2_KBD_CMD, 1, 8'hFF, 8'h00);
        kbd_receive(1'b0);
        read_compare(SMCREG_READ_PS2_KBD_STAT, "status no ack");

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
